/* logic/loader_defs.svh */
`ifndef LOADER_DEFS_SVH
`define LOADER_DEFS_SVH

// AXI read side widths
`define LD_ADDR_W          32
`define LD_DATA_W          128
`define LD_XFER_W          32
`define LD_ARLEN_W         8

// One beat is 16 bytes
`define LD_BEAT_BYTES      16
`define LD_LOG_BEAT_BYTES  4

// Burst shape, kept short so a load spans several bursts
`define LD_BURST_BEATS     8
`define LD_LOG_BURST_BEATS 3
`define LD_BURST_BYTES     128

// Outstanding burst limit and the width of its slot count
`define LD_MAX_OUTSTANDING 2
`define LD_OUTSTANDING_W   2

// Per-load counters, byte count minus beat and burst bits
`define LD_BEAT_CNT_W      28
`define LD_BURST_CNT_W     25

// Column lanes and table geometry
`define LD_NUM_COL         8
`define LD_INSTR_W         32
`define LD_TABLE_DEPTH     16
`define LD_TABLE_ADDR_W    4
`define LD_COLS_PER_BEAT   4
`define LD_NUM_GROUPS      2
`define LD_GROUP_W         2
`define LD_CYCLE_W         32

`endif

/* logic/axi_read_pkg.sv */
`include "loader_defs.svh"

package axi_read_pkg;

  // Byte address on AR
  typedef logic [`LD_ADDR_W-1:0] addr_t;

  // One R data beat
  typedef logic [`LD_DATA_W-1:0] beat_t;

  // arlen, beats minus one
  typedef logic [`LD_ARLEN_W-1:0] burst_len_t;

  // Requested load size in bytes
  typedef logic [`LD_XFER_W-1:0] xfer_size_t;

  // Beats in a load
  typedef logic [`LD_BEAT_CNT_W-1:0] beat_count_t;

  // Bursts in a load
  typedef logic [`LD_BURST_CNT_W-1:0] burst_count_t;

endpackage

/* logic/table_pkg.sv */
`include "loader_defs.svh"

package table_pkg;

  // One instruction table entry
  typedef logic [`LD_INSTR_W-1:0] instr_t;

  // Program counter, same width as the table address
  typedef logic [`LD_TABLE_ADDR_W-1:0] pc_t;

  // One write enable per column lane
  // Bit c belongs to lane c
  typedef logic [`LD_NUM_COL-1:0] col_mask_t;

  // Free-running cycle count
  // wraps at full width
  typedef logic [`LD_CYCLE_W-1:0] cycle_t;

endpackage

/* logic/burst_reader.sv */
`timescale 1ns/1ps
`include "loader_defs.svh"
`default_nettype none

module burst_reader (
  input  logic                     aclk,
  input  logic                     areset,
  // Load request, sampled with the strobe
  input  logic                     ctrl_start,
  input  axi_read_pkg::addr_t      ctrl_addr_offset,
  input  axi_read_pkg::xfer_size_t ctrl_xfer_size,
  // AXI4 read address channel
  output logic                     arvalid,
  input  logic                     arready,
  output axi_read_pkg::addr_t      araddr,
  output axi_read_pkg::burst_len_t arlen,
  // AXI4 read data channel
  input  logic                     rvalid,
  output logic                     rready,
  input  axi_read_pkg::beat_t      rdata,
  input  logic                     rlast,
  // Accepted beats and end of load
  output logic                     beat_valid,
  output axi_read_pkg::beat_t      beat_data,
  output logic                     load_done
);

  typedef logic [`LD_OUTSTANDING_W-1:0] slot_t;

  localparam axi_read_pkg::addr_t BURST_MASK = axi_read_pkg::addr_t'(`LD_BURST_BYTES - 1);
  localparam axi_read_pkg::addr_t BURST_STEP = axi_read_pkg::addr_t'(`LD_BURST_BYTES);
  localparam axi_read_pkg::burst_len_t FULL_LEN =
    axi_read_pkg::burst_len_t'(`LD_BURST_BEATS - 1);
  localparam slot_t SLOTS_INIT = slot_t'(`LD_MAX_OUTSTANDING);

  logic                       start_d1;
  axi_read_pkg::beat_count_t  last_beat_r;
  axi_read_pkg::addr_t        base_addr_r;
  axi_read_pkg::burst_count_t last_burst;
  logic [`LD_LOG_BURST_BEATS-1:0] final_len;
  // AR side
  logic                       ar_active;
  axi_read_pkg::burst_count_t ar_to_go;
  logic                       ar_final;
  logic                       arxfer;
  logic                       stall_ar;
  slot_t                      slots;
  // R side
  logic                       rxfer;
  logic                       r_burst_end;
  logic                       r_active;
  axi_read_pkg::burst_count_t r_to_go;
  logic                       r_final;

  ////////////////////
  // Request capture
  ////////////////////

  always_ff @(posedge aclk) begin
    if (areset) begin
      start_d1 <= 1'b0;
    end else begin
      start_d1 <= ctrl_start;
    end
  end

  // Beat count kept as count minus one, arlen style
  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      // Partial beat rounds up
      if (|ctrl_xfer_size[`LD_LOG_BEAT_BYTES-1:0]) begin
        last_beat_r <= ctrl_xfer_size[`LD_XFER_W-1:`LD_LOG_BEAT_BYTES];
      end else begin
        last_beat_r <= ctrl_xfer_size[`LD_XFER_W-1:`LD_LOG_BEAT_BYTES] - 1'b1;
      end
      // Snap base down to a burst boundary
      base_addr_r <= ctrl_addr_offset & ~BURST_MASK;
    end
  end

  // Upper bits give bursts minus one, lower bits the last arlen
  assign last_burst = last_beat_r[`LD_BEAT_CNT_W-1:`LD_LOG_BURST_BEATS];
  assign final_len  = last_beat_r[`LD_LOG_BURST_BEATS-1:0];

  ////////////////////
  // AR channel
  ////////////////////

  assign arxfer   = arvalid & arready;
  assign ar_final = (ar_to_go == '0);
  assign stall_ar = (slots == '0);
  // Remainder only on the final burst
  assign arlen    = ar_final ? axi_read_pkg::burst_len_t'(final_len) : FULL_LEN;

  always_ff @(posedge aclk) begin
    if (areset) begin
      ar_active <= 1'b0;
      ar_to_go  <= '0;
    end else if (start_d1) begin
      ar_active <= 1'b1;
      ar_to_go  <= last_burst;
    end else if (arxfer) begin
      if (ar_final) begin
        ar_active <= 1'b0;
      end else begin
        ar_to_go <= ar_to_go - 1'b1;
      end
    end
  end

  // Holds until arready, then a gap cycle before the next request
  always_ff @(posedge aclk) begin
    if (areset) begin
      arvalid <= 1'b0;
    end else if (arvalid) begin
      if (arready) begin
        arvalid <= 1'b0;
      end
    end else if (ar_active && !stall_ar) begin
      arvalid <= 1'b1;
    end
  end

  // Steps one burst per accepted request
  always_ff @(posedge aclk) begin
    if (start_d1) begin
      araddr <= base_addr_r;
    end else if (arxfer) begin
      araddr <= araddr + BURST_STEP;
    end
  end

  // Free slots, taken on AR and returned on rlast
  always_ff @(posedge aclk) begin
    if (areset) begin
      slots <= SLOTS_INIT;
    end else begin
      case ({arxfer, r_burst_end})
        2'b10:   slots <= slots - 1'b1;
        2'b01:   slots <= slots + 1'b1;
        default: slots <= slots;
      endcase
    end
  end

  ////////////////////
  // R channel
  ////////////////////

  // No back-pressure on read data
  always_ff @(posedge aclk) begin
    if (areset) begin
      rready <= 1'b0;
    end else begin
      rready <= 1'b1;
    end
  end

  assign rxfer       = rvalid & rready;
  assign r_burst_end = rxfer & rlast & r_active;
  assign r_final     = (r_to_go == '0);
  assign beat_valid  = rxfer;
  assign beat_data   = rdata;

  always_ff @(posedge aclk) begin
    if (areset) begin
      r_active <= 1'b0;
      r_to_go  <= '0;
    end else if (start_d1) begin
      r_active <= 1'b1;
      r_to_go  <= last_burst;
    end else if (r_burst_end) begin
      if (r_final) begin
        r_active <= 1'b0;
      end else begin
        r_to_go <= r_to_go - 1'b1;
      end
    end
  end

  // One cycle after the final rlast
  always_ff @(posedge aclk) begin
    if (areset) begin
      load_done <= 1'b0;
    end else begin
      load_done <= r_burst_end & r_final;
    end
  end

endmodule

`default_nettype wire

/* logic/table_fill.sv */
`timescale 1ns/1ps
`include "loader_defs.svh"
`default_nettype none

module table_fill (
  input  logic                 aclk,
  input  logic                 areset,
  input  logic                 beat_valid,
  input  logic                 load_done,
  output table_pkg::pc_t       wr_addr,
  output table_pkg::col_mask_t wr_en
);

  typedef logic [`LD_GROUP_W-1:0] group_t;

  localparam table_pkg::pc_t LAST_ADDR = table_pkg::pc_t'(`LD_TABLE_DEPTH - 1);
  // Lowest group of columns, one per instruction slice
  localparam table_pkg::col_mask_t GROUP_MASK =
    table_pkg::col_mask_t'((1 << `LD_COLS_PER_BEAT) - 1);
  localparam group_t PAST_GROUPS = group_t'(`LD_NUM_GROUPS);

  group_t group_r;
  logic   group_open;
  logic   addr_wrap;

  assign addr_wrap  = beat_valid && (wr_addr == LAST_ADDR);
  // Still inside table capacity
  assign group_open = (group_r < PAST_GROUPS);

  ////////////////////
  // Beat position
  ////////////////////

  // Address counts beats modulo the table depth
  always_ff @(posedge aclk) begin
    if (areset || load_done) begin
      wr_addr <= '0;
    end else if (beat_valid) begin
      wr_addr <= wr_addr + 1'b1;
    end
  end

  // Group advances on wrap and parks one past the last group
  always_ff @(posedge aclk) begin
    if (areset || load_done) begin
      group_r <= '0;
    end else if (addr_wrap && group_open) begin
      group_r <= group_r + 1'b1;
    end
  end

  // Enables follow the group directly so the first beat lands
  // Beats past capacity enable nothing
  always_comb begin
    wr_en = '0;
    if (beat_valid && group_open) begin
      wr_en = GROUP_MASK << (group_r * `LD_COLS_PER_BEAT);
    end
  end

endmodule

`default_nettype wire

/* logic/column_lane.sv */
`timescale 1ns/1ps
`include "loader_defs.svh"
`default_nettype none

module column_lane (
  input  logic              aclk,
  input  logic              areset,
  // Table write side, from the fill logic
  input  logic              wr_en,
  input  table_pkg::pc_t    wr_addr,
  input  table_pkg::instr_t wr_data,
  // Program counter controls
  input  logic              pc_clken,
  input  logic              pc_load,
  input  logic              pc_incr,
  input  table_pkg::pc_t    pc_load_value,
  // Current pc and the word it points at
  output table_pkg::pc_t    pc,
  output table_pkg::instr_t instr
);

  // One entry per table address
  table_pkg::instr_t table_mem [`LD_TABLE_DEPTH];

  ////////////////////
  // Instruction table
  ////////////////////

  always_ff @(posedge aclk) begin
    if (wr_en) begin
      table_mem[wr_addr] <= wr_data;
    end
  end

  // Registered read, one cycle behind pc
  always_ff @(posedge aclk) begin
    instr <= table_mem[pc];
  end

  ////////////////////
  // Program counter
  ////////////////////

  // Load beats incr, nothing moves without clken
  always_ff @(posedge aclk) begin
    if (areset) begin
      pc <= '0;
    end else if (pc_clken) begin
      if (pc_load) begin
        pc <= pc_load_value;
      end else if (pc_incr) begin
        pc <= pc + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/table_loader_top.sv */
`timescale 1ns/1ps
`include "loader_defs.svh"
`default_nettype none

module table_loader_top (
  input  logic                                  aclk,
  input  logic                                  areset,
  // Load control
  input  logic                                  ctrl_start,
  input  axi_read_pkg::addr_t                   ctrl_addr_offset,
  input  axi_read_pkg::xfer_size_t              ctrl_xfer_size,
  output logic                                  ctrl_done,
  // AXI4 read master
  output logic                                  arvalid,
  input  logic                                  arready,
  output axi_read_pkg::addr_t                   araddr,
  output axi_read_pkg::burst_len_t              arlen,
  input  logic                                  rvalid,
  output logic                                  rready,
  input  axi_read_pkg::beat_t                   rdata,
  input  logic                                  rlast,
  // Per-column program counter controls
  input  logic [`LD_NUM_COL-1:0]                pc_clken,
  input  logic [`LD_NUM_COL-1:0]                pc_load,
  input  logic [`LD_NUM_COL-1:0]                pc_incr,
  input  table_pkg::pc_t [`LD_NUM_COL-1:0]      pc_load_value,
  // Per-column outputs
  output table_pkg::pc_t [`LD_NUM_COL-1:0]      pc,
  output table_pkg::instr_t [`LD_NUM_COL-1:0]   instr,
  output table_pkg::cycle_t                     cycle_register
);

  logic                 beat_valid;
  axi_read_pkg::beat_t  beat_data;
  logic                 load_done;
  table_pkg::pc_t       wr_addr;
  table_pkg::col_mask_t wr_en;

  // AXI side, bursts in and beats out
  burst_reader u_reader (
    .aclk             (aclk),
    .areset           (areset),
    .ctrl_start       (ctrl_start),
    .ctrl_addr_offset (ctrl_addr_offset),
    .ctrl_xfer_size   (ctrl_xfer_size),
    .arvalid          (arvalid),
    .arready          (arready),
    .araddr           (araddr),
    .arlen            (arlen),
    .rvalid           (rvalid),
    .rready           (rready),
    .rdata            (rdata),
    .rlast            (rlast),
    .beat_valid       (beat_valid),
    .beat_data        (beat_data),
    .load_done        (load_done)
  );

  assign ctrl_done = load_done;

  // Placement of beats into column groups
  table_fill u_fill (
    .aclk       (aclk),
    .areset     (areset),
    .beat_valid (beat_valid),
    .load_done  (load_done),
    .wr_addr    (wr_addr),
    .wr_en      (wr_en)
  );

  ////////////////////
  // Column lanes
  ////////////////////

  for (genvar c = 0; c < `LD_NUM_COL; c++) begin : g_lane
    // Lowest slice goes to the first column of each group
    localparam int SLICE = c % `LD_COLS_PER_BEAT;

    column_lane u_lane (
      .aclk          (aclk),
      .areset        (areset),
      .wr_en         (wr_en[c]),
      .wr_addr       (wr_addr),
      .wr_data       (beat_data[SLICE*`LD_INSTR_W +: `LD_INSTR_W]),
      .pc_clken      (pc_clken[c]),
      .pc_load       (pc_load[c]),
      .pc_incr       (pc_incr[c]),
      .pc_load_value (pc_load_value[c]),
      .pc            (pc[c]),
      .instr         (instr[c])
    );
  end

  // Cycle counter, restarts on every start strobe and wraps
  always_ff @(posedge aclk) begin
    if (areset || ctrl_start) begin
      cycle_register <= '0;
    end else begin
      cycle_register <= cycle_register + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* verification/table_checker.sv */
`timescale 1ns/1ps
`include "loader_defs.svh"

module table_checker (
  input  logic                                aclk,
  input  logic                                areset,
  input  logic                                ctrl_start,
  input  axi_read_pkg::addr_t                 ctrl_addr_offset,
  input  axi_read_pkg::xfer_size_t            ctrl_xfer_size,
  input  logic                                ctrl_done,
  input  logic                                arvalid,
  input  logic                                arready,
  input  axi_read_pkg::addr_t                 araddr,
  input  axi_read_pkg::burst_len_t            arlen,
  input  logic                                rvalid,
  input  logic                                rready,
  input  logic                                rlast,
  input  table_pkg::pc_t [`LD_NUM_COL-1:0]    pc,
  input  table_pkg::instr_t [`LD_NUM_COL-1:0] instr,
  input  table_pkg::cycle_t                   cycle_register,
  // Expected values for one column
  input  logic                                chk_req,
  input  logic [2:0]                          chk_col,
  input  table_pkg::pc_t                      chk_pc,
  input  table_pkg::instr_t                   chk_instr,
  output int                                  error_count,
  output int                                  check_count,
  output int                                  load_count,
  output int                                  done_count
);

  longint      exp_beats;
  longint      exp_bursts;
  logic [31:0] exp_base;
  int          ar_idx;
  int          r_bursts;
  int          outstanding;
  logic        done_due;
  logic        ar_wait;
  logic [31:0] ar_wait_addr;
  logic        started;
  logic [31:0] cyc_model;

  initial begin
    error_count = 0;
    check_count = 0;
    load_count  = 0;
    done_count  = 0;
    done_due    = 1'b0;
    ar_wait     = 1'b0;
    started     = 1'b0;
    outstanding = 0;
  end

  task automatic flag(input string msg);
    $display("FAILED at %0t: %s", $time, msg);
    error_count++;
  endtask

  always @(posedge aclk) begin
    logic [7:0] exp_len;
    if (!areset) begin
      ////////////////////
      // Done pulse
      ////////////////////
      if (done_due) begin
        if (ctrl_done !== 1'b1) flag("ctrl_done missing after final rlast");
        if (ar_idx != int'(exp_bursts)) flag($sformatf("%0d ARs, expected %0d",
                                                       ar_idx, exp_bursts));
        done_count++;
        done_due = 1'b0;
      end else if (ctrl_done === 1'b1) begin
        flag("unexpected ctrl_done pulse");
      end

      // New load, expected shape from base and byte count
      if (ctrl_start) begin
        exp_base   = (ctrl_addr_offset / `LD_BURST_BYTES) * `LD_BURST_BYTES;
        exp_beats  = (longint'(ctrl_xfer_size) + 15) / 16;
        exp_bursts = (exp_beats + `LD_BURST_BEATS - 1) / `LD_BURST_BEATS;
        ar_idx     = 0;
        r_bursts   = 0;
        load_count++;
      end

      ////////////////////
      // AR channel
      ////////////////////
      if (ar_wait && (arvalid !== 1'b1 || araddr !== ar_wait_addr)) begin
        flag("arvalid or araddr changed before arready");
      end
      ar_wait      = arvalid && !arready;
      ar_wait_addr = araddr;
      if (arvalid && arready) begin
        if (ar_idx >= int'(exp_bursts)) flag("AR issued beyond the bursts of the load");
        if (ar_idx == int'(exp_bursts) - 1) begin
          exp_len = 8'((exp_beats - 1) % `LD_BURST_BEATS);
        end else begin
          exp_len = 8'(`LD_BURST_BEATS - 1);
        end
        if (araddr !== exp_base + 32'(ar_idx * `LD_BURST_BYTES)) begin
          flag($sformatf("araddr %h, expected %h", araddr,
                         exp_base + 32'(ar_idx * `LD_BURST_BYTES)));
        end
        if (arlen !== exp_len) flag($sformatf("arlen %0d, expected %0d", arlen, exp_len));
        ar_idx++;
        outstanding++;
      end

      // Burst ends and the outstanding limit
      if (rvalid && rready && rlast) begin
        outstanding--;
        r_bursts++;
        if (r_bursts == int'(exp_bursts)) done_due = 1'b1;
      end
      if (outstanding > `LD_MAX_OUTSTANDING) flag($sformatf("%0d bursts outstanding",
                                                            outstanding));

      // Read data is never back-pressured once running
      if (started && rready !== 1'b1) flag("rready low after the first load started");

      // Cycle counter against cycles since the last start
      if (started && cycle_register !== cyc_model) begin
        flag($sformatf("cycle_register %0d, expected %0d", cycle_register, cyc_model));
      end
      if (ctrl_start) begin
        cyc_model = '0;
        started   = 1'b1;
      end else begin
        cyc_model = cyc_model + 1;
      end

      // Column compare
      if (chk_req) begin
        check_count++;
        if (pc[chk_col] !== chk_pc || instr[chk_col] !== chk_instr) begin
          flag($sformatf("column %0d pc %0d instr %h, expected pc %0d instr %h", chk_col,
                         pc[chk_col], instr[chk_col], chk_pc, chk_instr));
        end
      end
    end
  end

endmodule

/* verification/tb_table_loader.sv */
`timescale 1ns/1ps
`include "loader_defs.svh"

module tb_table_loader;

  localparam int MAX_RECORDS = 64;

  logic                                 aclk;
  logic                                 areset;
  logic                                 ctrl_start;
  axi_read_pkg::addr_t                  ctrl_addr_offset;
  axi_read_pkg::xfer_size_t             ctrl_xfer_size;
  logic                                 ctrl_done;
  logic                                 arvalid;
  logic                                 arready;
  axi_read_pkg::addr_t                  araddr;
  axi_read_pkg::burst_len_t             arlen;
  logic                                 rvalid;
  logic                                 rready;
  axi_read_pkg::beat_t                  rdata;
  logic                                 rlast;
  logic [`LD_NUM_COL-1:0]               pc_clken;
  logic [`LD_NUM_COL-1:0]               pc_load;
  logic [`LD_NUM_COL-1:0]               pc_incr;
  table_pkg::pc_t [`LD_NUM_COL-1:0]     pc_load_value;
  table_pkg::pc_t [`LD_NUM_COL-1:0]     pc;
  table_pkg::instr_t [`LD_NUM_COL-1:0]  instr;
  table_pkg::cycle_t                    cycle_register;

  // Requests from the command stream to the checker
  logic                                 chk_req;
  logic [2:0]                           chk_col;
  table_pkg::pc_t                       chk_pc;
  table_pkg::instr_t                    chk_instr;
  int                                   error_count;
  int                                   check_count;
  int                                   load_count;
  int                                   done_count;
  int                                   record_errors;

  // Command records, four words each
  logic [31:0] tests [0:4*MAX_RECORDS-1];
  logic [31:0] pattern;
  // Slave side request queue
  logic [31:0] ar_addr_q [$];
  logic [7:0]  ar_len_q [$];
  int          beat_idx;
  int          cycle_count;
  int          cycle_limit;
  logic        limit_ready;
  int          expected_loads;

  table_loader_top dut (
    .aclk             (aclk),
    .areset           (areset),
    .ctrl_start       (ctrl_start),
    .ctrl_addr_offset (ctrl_addr_offset),
    .ctrl_xfer_size   (ctrl_xfer_size),
    .ctrl_done        (ctrl_done),
    .arvalid          (arvalid),
    .arready          (arready),
    .araddr           (araddr),
    .arlen            (arlen),
    .rvalid           (rvalid),
    .rready           (rready),
    .rdata            (rdata),
    .rlast            (rlast),
    .pc_clken         (pc_clken),
    .pc_load          (pc_load),
    .pc_incr          (pc_incr),
    .pc_load_value    (pc_load_value),
    .pc               (pc),
    .instr            (instr),
    .cycle_register   (cycle_register)
  );

  table_checker chk (
    .aclk             (aclk),
    .areset           (areset),
    .ctrl_start       (ctrl_start),
    .ctrl_addr_offset (ctrl_addr_offset),
    .ctrl_xfer_size   (ctrl_xfer_size),
    .ctrl_done        (ctrl_done),
    .arvalid          (arvalid),
    .arready          (arready),
    .araddr           (araddr),
    .arlen            (arlen),
    .rvalid           (rvalid),
    .rready           (rready),
    .rlast            (rlast),
    .pc               (pc),
    .instr            (instr),
    .cycle_register   (cycle_register),
    .chk_req          (chk_req),
    .chk_col          (chk_col),
    .chk_pc           (chk_pc),
    .chk_instr        (chk_instr),
    .error_count      (error_count),
    .check_count      (check_count),
    .load_count       (load_count),
    .done_count       (done_count)
  );

  // 40 ns clock
  always #20 aclk = ~aclk;

  // Four 32-bit words, each its own byte address plus the pattern
  function automatic axi_read_pkg::beat_t make_beat(input logic [31:0] addr);
    axi_read_pkg::beat_t w;
    for (int i = 0; i < `LD_COLS_PER_BEAT; i++) begin
      w[i*`LD_INSTR_W +: `LD_INSTR_W] = addr + 32'(i * 4) + pattern;
    end
    return w;
  endfunction

  ////////////////////
  // AXI slave model
  ////////////////////

  // In-order bursts, random arready and random beat gaps
  always @(posedge aclk) begin
    if (areset) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      if (arvalid && arready) begin
        ar_addr_q.push_back(araddr);
        ar_len_q.push_back(arlen);
      end
      arready <= ($urandom % 2) == 1;
      if (rvalid && rready) begin
        if (rlast) begin
          void'(ar_addr_q.pop_front());
          void'(ar_len_q.pop_front());
          beat_idx = 0;
        end else begin
          beat_idx++;
        end
      end
      if (ar_addr_q.size() > 0 && ($urandom % 4) != 0) begin
        rvalid <= 1'b1;
        rdata  <= make_beat(ar_addr_q[0] + 32'(beat_idx * 16));
        rlast  <= (beat_idx == int'(ar_len_q[0]));
      end else begin
        rvalid <= 1'b0;
      end
    end
  end

  // Watchdog on total cycles
  always @(posedge aclk) begin
    cycle_count <= cycle_count + 1;
    if (limit_ready && cycle_count > cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Testbench failed");
      $finish;
    end
  end

  ////////////////////
  // Command stream
  ////////////////////

  // One pc command on one column for one cycle
  task automatic drive_pc(input int col, input int op, input logic [31:0] value);
    @(posedge aclk);
    pc_clken[col]      <= (op != 2) && (op != 4);
    pc_load[col]       <= (op == 0) || (op == 3) || (op == 4);
    pc_incr[col]       <= (op == 1) || (op == 2) || (op == 3);
    pc_load_value[col] <= value[`LD_TABLE_ADDR_W-1:0];
    @(posedge aclk);
    pc_clken <= '0;
    pc_load  <= '0;
    pc_incr  <= '0;
  endtask

  // Start a load and wait for its done pulse
  task automatic run_load(input logic [31:0] base, input logic [31:0] size);
    @(posedge aclk);
    ctrl_start       <= 1'b1;
    ctrl_addr_offset <= base;
    ctrl_xfer_size   <= size;
    @(posedge aclk);
    ctrl_start <= 1'b0;
    while (ctrl_done !== 1'b1) begin
      @(posedge aclk);
    end
  endtask

  task automatic request_check(input int col, input logic [31:0] exp_pc,
                               input logic [31:0] exp_instr);
    @(posedge aclk);
    chk_req   <= 1'b1;
    chk_col   <= col[2:0];
    chk_pc    <= exp_pc[`LD_TABLE_ADDR_W-1:0];
    chk_instr <= exp_instr;
    @(posedge aclk);
    chk_req <= 1'b0;
  endtask

  initial begin
    int n;
    int beats;
    void'($urandom(39300));
    aclk             = 1'b0;
    areset           = 1'b1;
    ctrl_start       = 1'b0;
    ctrl_addr_offset = '0;
    ctrl_xfer_size   = '0;
    arready          = 1'b0;
    rvalid           = 1'b0;
    rdata            = '0;
    rlast            = 1'b0;
    pc_clken         = '0;
    pc_load          = '0;
    pc_incr          = '0;
    pc_load_value    = '0;
    chk_req          = 1'b0;
    chk_col          = '0;
    chk_pc           = '0;
    chk_instr        = '0;
    pattern          = '0;
    beat_idx         = 0;
    cycle_count      = 0;
    limit_ready      = 1'b0;
    expected_loads   = 0;
    record_errors    = 0;
    for (int i = 0; i < 4*MAX_RECORDS; i++) begin
      tests[i] = '0;
    end
    $readmemh("verification/table_loader_tests.txt", tests);

    // Limit from the beats and the number of commands
    n = 0;
    cycle_limit = 200;
    while (n < MAX_RECORDS && tests[n*4] != 0) begin
      if (tests[n*4] == 1) begin
        beats = int'((tests[n*4+2] + 32'd15) >> 4);
        cycle_limit += 20 * beats;
        expected_loads++;
      end
      cycle_limit += 200;
      n++;
    end
    limit_ready = 1'b1;

    repeat (5) @(posedge aclk);
    areset <= 1'b0;

    for (int r = 0; r < n; r++) begin
      case (tests[r*4])
        1: begin
          pattern = tests[r*4+3];
          run_load(tests[r*4+1], tests[r*4+2]);
        end
        2: drive_pc(int'(tests[r*4+1][2:0]), int'(tests[r*4+2]), tests[r*4+3]);
        3: request_check(int'(tests[r*4+1][2:0]), tests[r*4+2], tests[r*4+3]);
        default: begin
          $display("Unknown command %0h in record %0d", tests[r*4], r);
          record_errors++;
        end
      endcase
    end
    repeat (4) @(posedge aclk);

    $display("Closing: %0d errors, %0d checks, %0d loads, %0d done pulses",
             error_count + record_errors, check_count, load_count, done_count);
    if (error_count == 0 && record_errors == 0 &&
        done_count == expected_loads && load_count == expected_loads) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* verification/table_loader_tests.txt */
// Columns: op a b c in hex. op 1 load: base, byte count, data pattern
// op 2 pc: column, operation, value. op 3 check: column, pc, instr. op 0 ends
1 00001000 00000200 A5000000
2 0 0 0
3 0 0 A5001000
2 5 0 3
3 5 3 A5001134
2 7 0 F
3 7 F A50011FC
2 2 0 4
2 2 1 0
3 2 5 A5001058
2 2 2 0
3 2 5 A5001058
2 2 3 9
3 2 9 A5001098
2 2 4 1
3 2 9 A5001098
1 00002043 00000025 5A000000
2 1 0 2
3 1 2 5A002024
2 6 0 1
3 6 1 A5001118
2 0 0 3
3 0 3 A5001030
1 00003000 00000280 3C000000
2 3 0 F
3 3 F 3C0030FC
0 0 0 0

/* project.f */
+incdir+logic
logic/axi_read_pkg.sv
logic/table_pkg.sv
logic/burst_reader.sv
logic/table_fill.sv
logic/column_lane.sv
logic/table_loader_top.sv
verification/table_checker.sv
verification/tb_table_loader.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       ?= tb_table_loader
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Testbench failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
